/* include/u1e_consts.svh */
/* u1e control core constants
   bus widths, slot and settings addresses, reset values */
`ifndef U1E_CONSTS_SVH
`define U1E_CONSTS_SVH

//////////////////////////////
// host bus
`define U1E_DW 16
`define U1E_AW 11
`define U1E_SLOT_W 4      // address bits 10..7

//////////////////////////////
// settings bus
`define U1E_SET_AW 8
`define U1E_SET_DW 32

// settings register map
`define SR_CLEAR_FIFO 6   // 1 reg
`define SR_TIME64 28      // secs, ticks, command

//////////////////////////////
// reset and filler values
`define U1E_TICKS_PER_SEC 64000000
`define U1E_CGEN_RESET 2'b11   // sync_b high, ref_sel high
`define U1E_READ_FILLER 16'hBEEF

`endif

/* hdl/u1e_pkg.sv */
/* u1e shared types
   slot numbers, misc register offsets and time-load commands */
`include "u1e_consts.svh"

package u1e_pkg;

   typedef enum logic [`U1E_SLOT_W-1:0] {
      SLOT_MISC     = 4'd0,
      SLOT_SETTINGS = 4'd5
   } slot_e;

   // byte offsets inside slot 0
   typedef enum logic [6:0] {
      REG_LEDS        = 7'd0,
      REG_SWITCHES    = 7'd2,
      REG_CGEN_CTRL   = 7'd4,
      REG_CGEN_ST     = 7'd6,
      REG_TEST        = 7'd8,
      REG_RX_FRAMELEN = 7'd10,
      REG_TX_FRAMELEN = 7'd12,
      REG_XFER_RATE   = 7'd14
   } misc_reg_e;

   typedef enum logic [1:0] {
      TCMD_NONE     = 2'd0,
      TCMD_NOW      = 2'd1,
      TCMD_NEXT_PPS = 2'd2
   } time_cmd_e;

endpackage

/* hdl/wb_slave_decode.sv */
/* single-master bus decoder
   slot strobes from address bits 10..7, read mux and same-cycle ack */
`include "u1e_consts.svh"

module wb_slave_decode
(
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic [`U1E_AW-1:0]   wb_adr_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   input  logic [`U1E_DW-1:0]   misc_dat_i,
   output logic                 wb_ack_o,
   output logic [`U1E_DW-1:0]   wb_dat_o,
   output logic                 misc_stb_o,
   output logic                 set_stb_bus_o
);

   u1e_pkg::slot_e slot;
   logic           access;

   assign slot   = u1e_pkg::slot_e'(wb_adr_i[`U1E_AW-1 -: `U1E_SLOT_W]);
   assign access = wb_cyc_i & wb_stb_i;

   // every slot answers, dead ones included
   assign wb_ack_o = access;

   assign misc_stb_o    = access & (slot == u1e_pkg::SLOT_MISC);
   assign set_stb_bus_o = access & (slot == u1e_pkg::SLOT_SETTINGS);

   //////////////////////////////
   // read data
   always_comb
   begin
      case (slot)
         u1e_pkg::SLOT_MISC:
         begin
            wb_dat_o = misc_dat_i;
         end
         default:
         begin
            wb_dat_o = '0;            // write-only bridge and unmapped slots
         end
      endcase
   end

   a_ack_in_cyc : assert property (@(posedge wb_clk) disable iff (wb_rst)
      wb_ack_o |-> (wb_cyc_i && wb_stb_i))
      else $error("ack without cyc and stb");

endmodule

/* hdl/misc_regs.sv */
/* slot 0 misc registers
   leds, clock-gen control, test, frame length and rate; switch and status readback */
`include "u1e_consts.svh"

module misc_regs
(
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   input  logic                 misc_stb_i,
   input  logic                 wb_we_i,
   input  logic [6:0]           wb_adr_i,
   input  logic [`U1E_DW-1:0]   wb_dat_i,
   input  logic [7:0]           dip_sw_i,
   input  logic [2:0]           debug_pb_i,
   input  logic                 cgen_st_status_i,
   input  logic                 cgen_st_ld_i,
   input  logic                 cgen_st_refmon_i,
   input  logic [15:0]          rx_frame_len_i,
   output logic [`U1E_DW-1:0]   misc_dat_o,
   output logic [15:0]          leds_o,
   output logic                 cgen_sync_b_o,
   output logic                 cgen_ref_sel_o,
   output logic [15:0]          test_o,
   output logic [15:0]          tx_frame_len_o,
   output logic                 tx_enable_o,
   output logic                 rx_enable_o,
   output logic [7:0]           rate_o
);

   u1e_pkg::misc_reg_e reg_sel;
   logic [15:0]        reg_cgen_ctrl;
   logic [15:0]        xfer_rate;

   assign reg_sel = u1e_pkg::misc_reg_e'(wb_adr_i);

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         leds_o         <= '0;
         reg_cgen_ctrl  <= 16'(`U1E_CGEN_RESET);
         test_o         <= '0;
         tx_frame_len_o <= '0;
         xfer_rate      <= '0;
      end
      else if (misc_stb_i && wb_we_i)
      begin
         case (reg_sel)
            u1e_pkg::REG_LEDS:        leds_o         <= wb_dat_i;
            u1e_pkg::REG_CGEN_CTRL:   reg_cgen_ctrl  <= wb_dat_i;
            u1e_pkg::REG_TEST:        test_o         <= wb_dat_i;
            u1e_pkg::REG_TX_FRAMELEN: tx_frame_len_o <= wb_dat_i;
            u1e_pkg::REG_XFER_RATE:   xfer_rate      <= wb_dat_i;
            default: ;                                  // read-only offsets
         endcase
      end
   end

   assign {cgen_sync_b_o, cgen_ref_sel_o} = reg_cgen_ctrl[1:0];

   assign tx_enable_o = xfer_rate[15];
   assign rx_enable_o = xfer_rate[14];
   assign rate_o      = xfer_rate[7:0];

   //////////////////////////////
   // readback
   always_comb
   begin
      case (reg_sel)
         u1e_pkg::REG_LEDS:        misc_dat_o = leds_o;
         u1e_pkg::REG_SWITCHES:    misc_dat_o = {5'b0, debug_pb_i, dip_sw_i};
         u1e_pkg::REG_CGEN_CTRL:   misc_dat_o = reg_cgen_ctrl;
         u1e_pkg::REG_CGEN_ST:
            misc_dat_o = {13'b0, cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i};
         u1e_pkg::REG_TEST:        misc_dat_o = test_o;
         u1e_pkg::REG_RX_FRAMELEN: misc_dat_o = rx_frame_len_i;
         default:                  misc_dat_o = `U1E_READ_FILLER;  // write-only and holes
      endcase
   end

endmodule

/* hdl/settings_bus_16le.sv */
/* slot 5 settings bridge
   pairs little-endian halfword writes into 32-bit settings strobes, hosts fifo clear */
`include "u1e_consts.svh"

module settings_bus_16le
(
   input  logic                     wb_clk,
   input  logic                     wb_rst,
   input  logic                     set_stb_bus_i,
   input  logic                     wb_we_i,
   input  logic [6:0]               wb_adr_i,
   input  logic [`U1E_DW-1:0]       wb_dat_i,
   output logic                     set_stb_o,
   output logic [`U1E_SET_AW-1:0]   set_addr_o,
   output logic [`U1E_SET_DW-1:0]   set_data_o,
   output logic                     clear_tx_o,
   output logic                     clear_rx_o
);

   localparam logic [4:0] clear_idx = 5'(`SR_CLEAR_FIFO);

   logic [`U1E_DW-1:0] data_low;       // low half waiting for its partner
   logic               wr;
   logic               lo_wr;
   logic               hi_wr;
   logic [4:0]         reg_idx;

   assign wr      = set_stb_bus_i & wb_we_i;
   assign lo_wr   = wr & ~wb_adr_i[1];
   assign hi_wr   = wr & wb_adr_i[1];
   assign reg_idx = wb_adr_i[6:2];

   always_ff @(posedge wb_clk)
   begin
      if (lo_wr)
      begin
         data_low <= wb_dat_i;
      end
   end

   //////////////////////////////
   // strobe on the high half
   always_ff @(posedge wb_clk)
   begin
      if (hi_wr)
      begin
         set_addr_o <= {{(`U1E_SET_AW-5){1'b0}}, reg_idx};
         set_data_o <= {wb_dat_i, data_low};
      end
   end

   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         set_stb_o  <= 1'b0;
         clear_tx_o <= 1'b0;
         clear_rx_o <= 1'b0;
      end
      else
      begin
         set_stb_o  <= hi_wr;
         // fifo clear register, bits 1..0 of the assembled word
         clear_tx_o <= hi_wr & (reg_idx == clear_idx) & data_low[1];
         clear_rx_o <= hi_wr & (reg_idx == clear_idx) & data_low[0];
      end
   end

   // master drops stb after each ack, so high-half writes never land back to back
   a_stb_single : assert property (@(posedge wb_clk) disable iff (wb_rst)
      set_stb_o |=> !set_stb_o)
      else $error("settings strobe held for two cycles");

endmodule

/* hdl/vita_time64.sv */
/* vita 64-bit time counter
   seconds and ticks, loaded from the settings bus now or on the next pps edge */
`include "u1e_consts.svh"

module vita_time64
#(
   parameter logic [31:0] ticks_per_sec = 32'(`U1E_TICKS_PER_SEC)
)
(
   input  logic                     wb_clk,
   input  logic                     wb_rst,
   input  logic                     set_stb_i,
   input  logic [`U1E_SET_AW-1:0]   set_addr_i,
   input  logic [`U1E_SET_DW-1:0]   set_data_i,
   input  logic                     pps_i,
   output logic [63:0]              vita_time_o,
   output logic                     pps_o
);

   localparam logic [`U1E_SET_AW-1:0] addr_secs  = `U1E_SET_AW'(`SR_TIME64);
   localparam logic [`U1E_SET_AW-1:0] addr_ticks = `U1E_SET_AW'(`SR_TIME64 + 1);
   localparam logic [`U1E_SET_AW-1:0] addr_cmd   = `U1E_SET_AW'(`SR_TIME64 + 2);

   logic [31:0]         secs, ticks;
   logic [31:0]         pend_secs, pend_ticks;
   logic                armed;
   logic                pps_s1, pps_s2, pps_d;
   logic                cmd_wr;
   u1e_pkg::time_cmd_e  cmd;

   assign cmd_wr = set_stb_i & (set_addr_i == addr_cmd);
   assign cmd    = u1e_pkg::time_cmd_e'(set_data_i[1:0]);

   // pending values, no effect until a command
   always_ff @(posedge wb_clk)
   begin
      if (set_stb_i && (set_addr_i == addr_secs))
         pend_secs <= set_data_i;
      if (set_stb_i && (set_addr_i == addr_ticks))
         pend_ticks <= set_data_i;
   end

   //////////////////////////////
   // pps sync and edge detect
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         pps_s1 <= 1'b0;
         pps_s2 <= 1'b0;
         pps_d  <= 1'b0;
         pps_o  <= 1'b0;
      end
      else
      begin
         pps_s1 <= pps_i;
         pps_s2 <= pps_s1;
         pps_d  <= pps_s2;
         pps_o  <= pps_s2 & ~pps_d;   // rising edge only
      end
   end

   //////////////////////////////
   // counter and loads
   always_ff @(posedge wb_clk)
   begin
      if (wb_rst)
      begin
         secs  <= '0;
         ticks <= '0;
         armed <= 1'b0;
      end
      else if (cmd_wr && (cmd == u1e_pkg::TCMD_NOW))
      begin
         secs  <= pend_secs;
         ticks <= pend_ticks;
      end
      else if (armed && pps_o)
      begin
         secs  <= pend_secs;
         ticks <= pend_ticks;
         armed <= 1'b0;
      end
      else
      begin
         if (cmd_wr && (cmd == u1e_pkg::TCMD_NEXT_PPS))
            armed <= 1'b1;
         else if (cmd_wr && (cmd == u1e_pkg::TCMD_NONE))
            armed <= 1'b0;            // cancel a pending pps load
         if (ticks == ticks_per_sec - 1)
         begin
            ticks <= '0;
            secs  <= secs + 1;
         end
         else
            ticks <= ticks + 1;
      end
   end

   assign vita_time_o = {secs, ticks};

   // also catches an out-of-range ticks value arriving over the settings bus
   a_ticks_range : assert property (@(posedge wb_clk) disable iff (wb_rst)
      ticks < ticks_per_sec)
      else $error("ticks %0d out of range", ticks);

endmodule

/* hdl/u1e_ctrl_top.sv */
/* u1e host control core
   bus decoder, misc registers, settings bridge and vita time counter */
`include "u1e_consts.svh"

module u1e_ctrl_top
#(
   parameter logic [31:0] ticks_per_sec = 32'(`U1E_TICKS_PER_SEC)
)
(
   input  logic                 wb_clk,
   input  logic                 wb_rst,
   // host bus
   input  logic [`U1E_AW-1:0]   wb_adr_i,
   input  logic [`U1E_DW-1:0]   wb_dat_i,
   input  logic                 wb_we_i,
   input  logic                 wb_cyc_i,
   input  logic                 wb_stb_i,
   output logic [`U1E_DW-1:0]   wb_dat_o,
   output logic                 wb_ack_o,
   // board i/o
   input  logic [7:0]           dip_sw_i,
   input  logic [2:0]           debug_pb_i,
   input  logic                 cgen_st_status_i,
   input  logic                 cgen_st_ld_i,
   input  logic                 cgen_st_refmon_i,
   input  logic [15:0]          rx_frame_len_i,
   output logic [15:0]          leds_o,
   output logic                 cgen_sync_b_o,
   output logic                 cgen_ref_sel_o,
   output logic [15:0]          test_o,
   output logic [15:0]          tx_frame_len_o,
   output logic                 tx_enable_o,
   output logic                 rx_enable_o,
   output logic [7:0]           rate_o,
   output logic                 clear_tx_o,
   output logic                 clear_rx_o,
   // timing
   input  logic                 pps_i,
   output logic                 pps_o,
   output logic [63:0]          vita_time_o
);

   logic                    misc_stb, set_stb_bus;
   logic [`U1E_DW-1:0]      misc_dat;
   logic                    set_stb;
   logic [`U1E_SET_AW-1:0]  set_addr;
   logic [`U1E_SET_DW-1:0]  set_data;

   wb_slave_decode u_decode (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .wb_adr_i(wb_adr_i),
      .wb_cyc_i(wb_cyc_i), .wb_stb_i(wb_stb_i), .misc_dat_i(misc_dat),
      .wb_ack_o(wb_ack_o), .wb_dat_o(wb_dat_o),
      .misc_stb_o(misc_stb), .set_stb_bus_o(set_stb_bus));

   misc_regs u_misc (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .misc_stb_i(misc_stb), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i[6:0]), .wb_dat_i(wb_dat_i),
      .dip_sw_i(dip_sw_i), .debug_pb_i(debug_pb_i),
      .cgen_st_status_i(cgen_st_status_i), .cgen_st_ld_i(cgen_st_ld_i),
      .cgen_st_refmon_i(cgen_st_refmon_i), .rx_frame_len_i(rx_frame_len_i),
      .misc_dat_o(misc_dat), .leds_o(leds_o),
      .cgen_sync_b_o(cgen_sync_b_o), .cgen_ref_sel_o(cgen_ref_sel_o),
      .test_o(test_o), .tx_frame_len_o(tx_frame_len_o),
      .tx_enable_o(tx_enable_o), .rx_enable_o(rx_enable_o), .rate_o(rate_o));

   settings_bus_16le u_settings (
      .wb_clk(wb_clk), .wb_rst(wb_rst), .set_stb_bus_i(set_stb_bus), .wb_we_i(wb_we_i),
      .wb_adr_i(wb_adr_i[6:0]), .wb_dat_i(wb_dat_i),
      .set_stb_o(set_stb), .set_addr_o(set_addr), .set_data_o(set_data),
      .clear_tx_o(clear_tx_o), .clear_rx_o(clear_rx_o));

   vita_time64 #(.ticks_per_sec(ticks_per_sec)) u_time (
      .wb_clk(wb_clk), .wb_rst(wb_rst),
      .set_stb_i(set_stb), .set_addr_i(set_addr), .set_data_i(set_data),
      .pps_i(pps_i), .vita_time_o(vita_time_o), .pps_o(pps_o));

endmodule

/* tb/tb_u1e_ctrl.sv */
/* u1e control core testbench
   bus master, misc registers, fifo clear and vita time loads */
`include "u1e_consts.svh"

module tb_u1e_ctrl;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int ACK_TIMEOUT  = 16;   // cycles
   localparam int WAIT_TIMEOUT = 40;

   logic                 wb_clk, wb_rst;
   logic [`U1E_AW-1:0]   wb_adr_i;
   logic [`U1E_DW-1:0]   wb_dat_i, wb_dat_o;
   logic                 wb_we_i, wb_cyc_i, wb_stb_i, wb_ack_o;
   logic [7:0]           dip_sw_i, rate_o;
   logic [2:0]           debug_pb_i;
   logic                 cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i;
   logic [15:0]          rx_frame_len_i, leds_o, test_o, tx_frame_len_o;
   logic                 cgen_sync_b_o, cgen_ref_sel_o, tx_enable_o, rx_enable_o;
   logic                 clear_tx_o, clear_rx_o, pps_i, pps_o;
   logic [63:0]          vita_time_o;

   integer seed = 98545;
   int     err_cnt = 0;
   int     timeout_cnt = 0;
   int     tx_pulses = 0;
   int     rx_pulses = 0;

   u1e_ctrl_top #(.ticks_per_sec(32'd10)) uut (.*);

   initial
   begin
      wb_clk = 1'b0;
      forever #10 wb_clk = ~wb_clk;
   end

   // clear pulses seen at each rising edge
   always @(posedge wb_clk)
   begin
      if (clear_tx_o)
         tx_pulses++;
      if (clear_rx_o)
         rx_pulses++;
   end

   //////////////////////////////
   // helpers
   function automatic logic [`U1E_AW-1:0] bus_addr(input logic [3:0] slot,
                                                   input logic [6:0] offs);
      return {slot, offs};
   endfunction

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      assert (act === exp)
      else
      begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         err_cnt++;
      end
   endtask

   // one transfer, driven on the falling edge, sampled a quarter period later
   task automatic bus_cycle(input logic [`U1E_AW-1:0] adr, input logic we,
                            input logic [15:0] wdat, output logic [15:0] rdat);
      int waited;
      @(negedge wb_clk);
      wb_adr_i = adr;
      wb_we_i  = we;
      wb_dat_i = wdat;
      wb_cyc_i = 1'b1;
      wb_stb_i = 1'b1;
      waited   = 0;
      #5;
      while (!wb_ack_o && waited < ACK_TIMEOUT)
      begin
         @(negedge wb_clk);
         #5;
         waited++;
      end
      if (!wb_ack_o)
      begin
         $display("timeout: no bus ack for address %h", adr);
         timeout_cnt++;
         rdat = '0;
      end
      else
         rdat = wb_dat_o;
      @(posedge wb_clk);   // edge that ends the ack cycle
      @(negedge wb_clk);
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      wb_we_i  = 1'b0;
   endtask

   task automatic bus_write(input logic [`U1E_AW-1:0] adr, input logic [15:0] dat);
      logic [15:0] unused;
      bus_cycle(adr, 1'b1, dat, unused);
   endtask

   task automatic bus_read(input logic [`U1E_AW-1:0] adr, output logic [15:0] dat);
      bus_cycle(adr, 1'b0, 16'h0, dat);
   endtask

   // low half first, high half fires the strobe
   task automatic settings_write(input logic [4:0] idx, input logic [31:0] data);
      bus_write(bus_addr(u1e_pkg::SLOT_SETTINGS, {idx, 2'b00}), data[15:0]);
      bus_write(bus_addr(u1e_pkg::SLOT_SETTINGS, {idx, 2'b10}), data[31:16]);
   endtask

   task automatic check_fifo_clear(input logic [31:0] data, input int exp_tx,
                                   input int exp_rx);
      int n;
      tx_pulses = 0;
      rx_pulses = 0;
      settings_write(`SR_CLEAR_FIFO, data);
      n = 0;
      while (tx_pulses + rx_pulses == 0 && n < WAIT_TIMEOUT)
      begin
         @(negedge wb_clk);
         n++;
      end
      if (tx_pulses + rx_pulses == 0)
      begin
         $display("timeout: no fifo clear pulse after settings write");
         timeout_cnt++;
      end
      repeat (4) @(negedge wb_clk);   // catch a second pulse
      check_value("clear_tx_count", exp_tx, tx_pulses);
      check_value("clear_rx_count", exp_rx, rx_pulses);
   endtask

   //////////////////////////////
   // stimulus
   initial
   begin
      logic [15:0] v, rd;
      logic [31:0] s_val, t_val;
      int          n;

      wb_rst = 1'b1;
      wb_adr_i = '0;
      wb_dat_i = '0;
      wb_we_i = 1'b0;
      wb_cyc_i = 1'b0;
      wb_stb_i = 1'b0;
      dip_sw_i = '0;
      debug_pb_i = '0;
      cgen_st_status_i = 1'b0;
      cgen_st_ld_i = 1'b0;
      cgen_st_refmon_i = 1'b0;
      rx_frame_len_i = '0;
      pps_i = 1'b0;

      repeat (5) @(negedge wb_clk);
      // still in reset, counter frozen
      check_value("reset_cgen_sync_b", 1, cgen_sync_b_o);
      check_value("reset_cgen_ref_sel", 1, cgen_ref_sel_o);
      check_value("reset_leds", 0, leds_o);
      check_value("reset_tx_frame_len", 0, tx_frame_len_o);
      check_value("reset_rate", 0, rate_o);
      check_value("reset_vita_time", 0, vita_time_o);
      check_value("reset_clear_tx", 0, clear_tx_o);
      check_value("reset_clear_rx", 0, clear_rx_o);
      wb_rst = 1'b0;

      // misc read-back
      v = $random(seed);
      bus_write(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_LEDS), v);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_LEDS), rd);
      check_value("leds_readback", v, rd);
      check_value("leds_out", v, leds_o);
      v = $random(seed);
      bus_write(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_CGEN_CTRL), v);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_CGEN_CTRL), rd);
      check_value("cgen_ctrl_readback", v, rd);
      check_value("cgen_sync_b", v[1], cgen_sync_b_o);
      check_value("cgen_ref_sel", v[0], cgen_ref_sel_o);
      v = $random(seed);
      bus_write(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_TEST), v);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_TEST), rd);
      check_value("test_readback", v, rd);
      check_value("test_out", v, test_o);

      dip_sw_i = $random(seed);
      debug_pb_i = $random(seed);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_SWITCHES), rd);
      // buttons sit just above the eight dip switches
      check_value("switches_read", (16'(debug_pb_i) << 8) | 16'(dip_sw_i), rd);
      {cgen_st_status_i, cgen_st_ld_i, cgen_st_refmon_i} = 3'b110;
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_CGEN_ST), rd);
      check_value("cgen_status_read", 16'h0006, rd);
      rx_frame_len_i = $random(seed);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_RX_FRAMELEN), rd);
      check_value("rx_frame_len_read", rx_frame_len_i, rd);

      // write-only registers read the filler
      v = $random(seed);
      bus_write(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_TX_FRAMELEN), v);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_TX_FRAMELEN), rd);
      check_value("tx_frame_len_read", `U1E_READ_FILLER, rd);
      check_value("tx_frame_len_out", v, tx_frame_len_o);
      v = $random(seed);
      bus_write(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_XFER_RATE), v);
      bus_read(bus_addr(u1e_pkg::SLOT_MISC, u1e_pkg::REG_XFER_RATE), rd);
      check_value("xfer_rate_read", `U1E_READ_FILLER, rd);
      check_value("tx_enable", v[15], tx_enable_o);
      check_value("rx_enable", v[14], rx_enable_o);
      check_value("rate", v[7:0], rate_o);

      // dead slot still acks
      bus_read(bus_addr(4'd9, 7'd0), rd);
      check_value("unmapped_read", 0, rd);

      check_fifo_clear(32'h2, 1, 0);
      check_fifo_clear(32'h1, 0, 1);

      //////////////////////////////
      // time loads
      s_val = $random(seed);
      settings_write(`SR_TIME64, s_val);
      settings_write(`SR_TIME64 + 1, 32'h0);
      settings_write(`SR_TIME64 + 2, {30'b0, u1e_pkg::TCMD_NOW});
      n = 0;
      while (vita_time_o[63:32] !== s_val && n < WAIT_TIMEOUT)
      begin
         @(negedge wb_clk);
         n++;
      end
      check_value("now_load_secs", s_val, vita_time_o[63:32]);
      repeat (10) @(negedge wb_clk);
      check_value("now_secs_plus_one", s_val + 32'd1, vita_time_o[63:32]);
      assert (vita_time_o[31:0] < 10)
      else
      begin
         $display("ERR now_ticks_range expected <10 actual %0d", vita_time_o[31:0]);
         err_cnt++;
      end

      t_val = s_val + 32'd1000;
      settings_write(`SR_TIME64, t_val);
      settings_write(`SR_TIME64 + 2, {30'b0, u1e_pkg::TCMD_NEXT_PPS});
      repeat (4) @(negedge wb_clk);
      assert (vita_time_o[63:32] != t_val)
      else
      begin
         $display("ERR pps_not_early expected !=%h actual %h", t_val, vita_time_o[63:32]);
         err_cnt++;
      end
      pps_i = 1'b1;
      n = 0;
      while (!pps_o && n < WAIT_TIMEOUT)
      begin
         @(negedge wb_clk);
         n++;
      end
      if (!pps_o)
      begin
         $display("timeout: pps_o never pulsed after pps_i rose");
         timeout_cnt++;
      end
      else
      begin
         @(negedge wb_clk);   // load lands at the end of the pulse
         check_value("pps_load_secs", t_val, vita_time_o[63:32]);
      end
      pps_i = 1'b0;

      repeat (2) @(negedge wb_clk);
      $display("errors %0d, timeouts %0d", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0)
      begin
         $display("STATUS: PASS");
      end
      else
      begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

/* all.f */
+incdir+include
hdl/u1e_pkg.sv
hdl/wb_slave_decode.sv
hdl/misc_regs.sv
hdl/settings_bus_16le.sv
hdl/vita_time64.sv
hdl/u1e_ctrl_top.sv
tb/tb_u1e_ctrl.sv

/* Bender.yml */
package:
  name: u1e_ctrl

export_include_dirs:
  - include

sources:
  - files:
      - hdl/u1e_pkg.sv
      - hdl/wb_slave_decode.sv
      - hdl/misc_regs.sv
      - hdl/settings_bus_16le.sv
      - hdl/vita_time64.sv
      - hdl/u1e_ctrl_top.sv
  - target: test
    files:
      - tb/tb_u1e_ctrl.sv
